/* hdl/nocFlitPkg.sv */
`default_nettype none

package nocFlitPkg;

  localparam int destWidth = 4;
  localparam int lengthWidth = 12; // Packet length counted in flits
  localparam int payloadWidth = 16;

  typedef enum logic [2:0]
  {
    kindHeader = 3'b001,
    kindBody = 3'b010,
    kindTail = 3'b100
  } flitKind;

  typedef struct packed
  {
    logic [destWidth-1:0] dest;
    logic [lengthWidth-1:0] length;
  } headerFields;

  // A header word carries route and length, every other kind carries raw data
  typedef union packed
  {
    headerFields header;
    logic [payloadWidth-1:0] data;
  } flitPayload;

  typedef struct packed
  {
    flitKind kind;
    flitPayload payload;
  } flit;

  function automatic logic isHeader(flit f);
    return f.kind == kindHeader;
  endfunction

  function automatic logic isTail(flit f);
    return f.kind == kindTail;
  endfunction

  function automatic logic [lengthWidth-1:0] headerLength(flit f);
    return f.payload.header.length;
  endfunction

endpackage

`default_nettype wire

/* hdl/nocRouterPkg.sv */
`default_nettype none

package nocRouterPkg;

  localparam int numPorts = 5;

  typedef enum logic [2:0]
  {
    portL = 3'd0,
    portN = 3'd1,
    portE = 3'd2,
    portW = 3'd3,
    portS = 3'd4
  } portIndex;

  // One-hot arbiter states, the granted ones follow the port order
  typedef enum logic [5:0]
  {
    stIdle = 6'b000001,
    stL = 6'b000010,
    stN = 6'b000100,
    stE = 6'b001000,
    stW = 6'b010000,
    stS = 6'b100000
  } arbState;

  typedef struct packed
  {
    nocFlitPkg::flit data;
    portIndex source;
  } outFlit;

  function automatic arbState portToState(portIndex p);
    return arbState'(6'b000010 << p);
  endfunction

  function automatic portIndex stateToPort(arbState s);
    portIndex p;
    p = portL; // Idle maps to Local, the only port it can move to
    for (int i = 0; i < numPorts; i++)
    begin
      if (s[i + 1])
        p = portIndex'(i);
    end
    return p;
  endfunction

endpackage

`default_nettype wire

/* hdl/flitFifo.sv */
`default_nettype none

module flitFifo
#(
  parameter int fifoDepth = 8
)
(
  input logic clk,
  input logic rst,
  input logic wrValid,
  input nocFlitPkg::flit wrFlit,
  input logic pop,
  output logic req,
  output nocFlitPkg::flit headFlit,
  output logic overflow
);
  import nocFlitPkg::*;

  localparam int ptrWidth = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
  localparam int cntWidth = $clog2(fifoDepth + 1);

  flit mem [fifoDepth];
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth-1:0] wrPtr;
  logic [cntWidth-1:0] used;
  logic full;
  logic doWrite;
  logic doPop;

  function automatic logic [ptrWidth-1:0] nextPtr(logic [ptrWidth-1:0] p);
    return (p == ptrWidth'(fifoDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full = (used == cntWidth'(fifoDepth));
  assign req = (used != '0);
  assign doWrite = wrValid && !full; // A full buffer refuses even if a pop frees a slot
  assign doPop = pop && req;
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= wrFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      used <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= nextPtr(wrPtr);
      if (doPop)
        rdPtr <= nextPtr(rdPtr);
      case ({doWrite, doPop})
        2'b10: used <= used + 1'b1;
        2'b01: used <= used - 1'b1;
        default: used <= used;
      endcase
      if (wrValid && full)
        overflow <= 1'b1; // Sticky until reset
    end
  end

endmodule

`default_nettype wire

/* hdl/packetTimer.sv */
`default_nettype none

module packetTimer
(
  input logic clk,
  input logic rst,
  input nocFlitPkg::flit headFlit,
  input logic runTimer,
  output logic timesUp
);
  import nocFlitPkg::*;

  logic [lengthWidth-1:0] limit;
  logic [lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (isHeader(headFlit))
        limit <= headerLength(headFlit); // Reloaded every cycle a header sits at the head
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // A zero limit expires at once
  assign timesUp = (count == limit);

endmodule

`default_nettype wire

/* hdl/switchArbiter.sv */
`default_nettype none

module switchArbiter
(
  input logic clk,
  input logic rst,
  input logic req [nocRouterPkg::numPorts],
  input nocFlitPkg::flit headFlit [nocRouterPkg::numPorts],
  output logic pop [nocRouterPkg::numPorts],
  output nocRouterPkg::portIndex grantPort
);
  import nocFlitPkg::*;
  import nocRouterPkg::*;

  arbState state;
  arbState nextState;
  flit timerFlit [numPorts];
  logic timesUp [numPorts];

  for (genvar i = 0; i < numPorts; i++)
  begin : gTimer
    // An empty buffer shows a stale entry that must not reload the limit
    assign timerFlit[i] = req[i] ? headFlit[i] : '0;

    packetTimer timer
    (
      .clk(clk),
      .rst(rst),
      .headFlit(timerFlit[i]),
      .runTimer(pop[i]), // The timer runs exactly on the popped cycles
      .timesUp(timesUp[i])
    );
  end

  assign grantPort = stateToPort(state);

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stIdle;
    else
      state <= nextState;
  end

  always_comb
  begin : nextStateLogic
    int cand;
    logic found;
    nextState = stIdle;
    found = 1'b0;
    cand = 0;
    for (int i = 0; i < numPorts; i++)
      pop[i] = 1'b0;

    if (state == stIdle)
    begin
      if (req[portL])
        nextState = stL; // Idle only ever wakes up for Local traffic
    end
    else if ($onehot(state))
    begin
      if (req[grantPort] && !timesUp[grantPort])
      begin
        pop[grantPort] = 1'b1;
        nextState = state;
      end
      else
      begin
        // Search the other ports in rotation order starting after the current one
        for (int k = 1; k < numPorts; k++)
        begin
          cand = (int'(grantPort) + k) % numPorts;
          if (!found && req[cand])
          begin
            nextState = portToState(portIndex'(cand));
            found = 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/outputStage.sv */
`default_nettype none

module outputStage
(
  input logic clk,
  input logic rst,
  input nocFlitPkg::flit headFlit [nocRouterPkg::numPorts],
  input nocRouterPkg::portIndex grantPort,
  input logic popAny,
  output logic outValid,
  output nocRouterPkg::outFlit outData
);

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= popAny;
  end

  // The head is still in place during the pop cycle
  always_ff @(posedge clk)
  begin
    if (popAny)
    begin
      outData.data <= headFlit[grantPort];
      outData.source <= grantPort;
    end
  end

endmodule

`default_nettype wire

/* hdl/routerOutputPort.sv */
`default_nettype none

module routerOutputPort
#(
  parameter int fifoDepth = 8
)
(
  input logic clk,
  input logic rst,
  input logic inValid [nocRouterPkg::numPorts],
  input nocFlitPkg::flit inFlit [nocRouterPkg::numPorts],
  output logic outValid,
  output nocRouterPkg::outFlit outData,
  output logic overflow [nocRouterPkg::numPorts]
);
  import nocFlitPkg::*;
  import nocRouterPkg::*;

  logic req [numPorts];
  flit headFlit [numPorts];
  logic pop [numPorts];
  portIndex grantPort;
  logic popAny;

  for (genvar i = 0; i < numPorts; i++)
  begin : gBuffer
    flitFifo #(
      .fifoDepth(fifoDepth)
    ) buffer
    (
      .clk(clk),
      .rst(rst),
      .wrValid(inValid[i]),
      .wrFlit(inFlit[i]),
      .pop(pop[i]),
      .req(req[i]),
      .headFlit(headFlit[i]),
      .overflow(overflow[i])
    );
  end

  switchArbiter arbiter
  (
    .clk(clk),
    .rst(rst),
    .req(req),
    .headFlit(headFlit),
    .pop(pop),
    .grantPort(grantPort)
  );

  always_comb
  begin
    popAny = 1'b0;
    for (int i = 0; i < numPorts; i++)
      popAny = popAny | pop[i];
  end

  outputStage outStage
  (
    .clk(clk),
    .rst(rst),
    .headFlit(headFlit),
    .grantPort(grantPort),
    .popAny(popAny),
    .outValid(outValid),
    .outData(outData)
  );

endmodule

`default_nettype wire

/* dv/routerOutputPort_assertions.sv */
`default_nettype none

module arbiterChecks
(
  input logic clk,
  input logic rst,
  input nocRouterPkg::arbState state,
  input logic req [nocRouterPkg::numPorts],
  input logic pop [nocRouterPkg::numPorts]
);
  import nocRouterPkg::*;

  logic [numPorts-1:0] reqVec;
  logic [numPorts-1:0] popVec;

  for (genvar i = 0; i < numPorts; i++)
  begin : gPack
    assign reqVec[i] = req[i];
    assign popVec[i] = pop[i];
  end

  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("Arbiter state is not one-hot");

  singlePop: assert property (@(posedge clk) disable iff (rst) $onehot0(popVec))
    else $error("More than one pop strobe is high");

  popNeedsReq: assert property (@(posedge clk) disable iff (rst) (popVec & ~reqVec) == '0)
    else $error("Pop raised on a port with no request");

endmodule

bind switchArbiter arbiterChecks checks
(
  .clk(clk),
  .rst(rst),
  .state(state),
  .req(req),
  .pop(pop)
);

`default_nettype wire

/* dv/routerOutputPortTb.sv */
`default_nettype none

module routerOutputPortTb;
  import nocFlitPkg::*;
  import nocRouterPkg::*;

  localparam int fifoDepth = 8;
  localparam int numPackets = 40;
  localparam int totalPackets = numPackets + 10; // Random packets plus directed and drain ones
  localparam int timeLimit = totalPackets * 6 * 20 * 10;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic inValid [numPorts];
  flit inFlit [numPorts];
  logic outValid;
  outFlit outData;
  logic overflow [numPorts];

  integer seed = 84;
  int errors = 0;
  int checks = 0;
  int cyc = 0;
  int started = 0;
  int sendLeft [numPorts];
  int pktLen [numPorts];
  logic forceStart [numPorts];
  logic randomMode = 1'b0;
  logic quiet = 1'b0;
  logic ovfTest = 1'b0;
  int ovfLeft = 0;
  flit expQ [numPorts][$];
  int stampQ [numPorts][$]; // First cycle in which the flit raises req
  int lastSrc = -1;
  int lastSeen = -10;
  int runLen = 0;
  int hdrLen [numPorts];

  routerOutputPort #(.fifoDepth(fifoDepth)) uut
  (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inFlit(inFlit),
    .outValid(outValid),
    .outData(outData),
    .overflow(overflow)
  );

  always #5 clk = ~clk;

  task automatic checkEq(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic reportFault(string what);
    errors++;
    $display("error at time %0t: %s", $time, what);
  endtask

  function automatic flit makeFlit(int idx, int len);
    flit f;
    f.payload.data = 16'($random(seed));
    if (idx == 0)
    begin
      f.kind = kindHeader;
      f.payload.header.length = 12'(len);
    end
    else
      f.kind = (idx == len - 1) ? kindTail : kindBody;
    return f;
  endfunction

  function automatic logic allDone();
    logic done;
    done = 1'b1;
    for (int p = 0; p < numPorts; p++)
      if (sendLeft[p] != 0 || expQ[p].size() != 0)
        done = 1'b0;
    return done;
  endfunction

  always @(posedge clk)
  begin : monitorAndDrive
    int src;
    int len;
    logic startNow;
    logic needDrain;
    flit f;
    flit expFlit;
    cyc++;
    if (!rst && outValid)
    begin
      src = int'(outData.source);
      if (quiet)
        reportFault($sformatf("flit from port %0d while the arbiter should be idle", src));
      else if (expQ[src].size() == 0)
        reportFault($sformatf("flit from port %0d that was never sent", src));
      else
      begin
        // A direct hand-over must skip only ports that had no request
        if (src != lastSrc && lastSrc >= 0 && cyc == lastSeen + 2)
          for (int k = 1; (lastSrc + k) % numPorts != src; k++)
            if (stampQ[(lastSrc + k) % numPorts].size() != 0 &&
                stampQ[(lastSrc + k) % numPorts][0] <= lastSeen - 1)
              reportFault($sformatf("port %0d skipped on grant move from %0d to %0d",
                                    (lastSrc + k) % numPorts, lastSrc, src));
        expFlit = expQ[src][0];
        checkEq("outData.data", expFlit, outData.data);
        void'(expQ[src].pop_front());
        void'(stampQ[src].pop_front());
        runLen = (src == lastSrc && cyc == lastSeen + 1) ? runLen + 1 : 1;
        if (expFlit.kind == kindHeader)
          hdrLen[src] = int'(expFlit.payload.header.length);
        if (runLen > hdrLen[src])
          reportFault($sformatf("burst from port %0d ran %0d flits, past header length %0d",
                                src, runLen, hdrLen[src]));
        lastSrc = src;
        lastSeen = cyc;
      end
    end
    if (!rst)
      for (int p = 0; p < numPorts; p++)
        if (!ovfTest || p != portS)
          checkEq($sformatf("overflow[%0d]", p), 0, overflow[p]);

    needDrain = 1'b0;
    for (int p = 1; p < numPorts; p++)
      if (expQ[p].size() != 0)
        needDrain = 1'b1; // Idle only wakes for Local traffic
    for (int p = 0; p < numPorts; p++)
    begin
      startNow = 1'b0;
      len = 3;
      if (sendLeft[p] == 0)
      begin
        if (forceStart[p])
        begin
          startNow = 1'b1;
          forceStart[p] = 1'b0;
        end
        else if (randomMode && started < numPackets && ($random(seed) & 7) == 0)
        begin
          len = (($random(seed) & 32'h7fff_ffff) % 6) + 1;
          if (expQ[p].size() + len <= fifoDepth)
          begin
            startNow = 1'b1;
            started++;
          end
        end
        else if (randomMode && started >= numPackets && p == 0 && needDrain &&
                 expQ[0].size() == 0)
          startNow = 1'b1;
        if (startNow)
        begin
          pktLen[p] = len;
          sendLeft[p] = len;
        end
      end
      if (sendLeft[p] > 0)
      begin
        f = makeFlit(pktLen[p] - sendLeft[p], pktLen[p]);
        inValid[p] <= 1'b1;
        inFlit[p] <= f;
        expQ[p].push_back(f);
        stampQ[p].push_back(cyc + 1);
        sendLeft[p]--;
      end
      else
        inValid[p] <= 1'b0;
    end
    if (ovfLeft > 0)
    begin
      inValid[portS] <= 1'b1; // These flits are meant to be lost or stuck
      inFlit[portS] <= makeFlit(1, 3);
      ovfLeft--;
    end
  end

  initial
  begin
    for (int p = 0; p < numPorts; p++)
    begin
      inValid[p] = 1'b0;
      inFlit[p] = '0;
      sendLeft[p] = 0;
      pktLen[p] = 0;
      forceStart[p] = 1'b0;
      hdrLen[p] = 0;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    quiet = 1'b1;
    repeat (20) @(negedge clk);
    $display("test idleAfterReset finished, errors %0d", errors);

    for (int p = 1; p < numPorts; p++)
      forceStart[p] = 1'b1;
    repeat (30) @(negedge clk);
    quiet = 1'b0;
    forceStart[portL] = 1'b1;
    @(negedge clk);
    while (!allDone())
      @(negedge clk);
    $display("test localWake finished, errors %0d", errors);

    randomMode = 1'b1;
    while (started < numPackets || !allDone())
      @(negedge clk);
    randomMode = 1'b0;
    $display("test randomTraffic finished, errors %0d", errors);

    repeat (5) @(negedge clk);
    ovfTest = 1'b1;
    quiet = 1'b1;
    ovfLeft = fifoDepth + 1;
    repeat (fifoDepth + 1) @(negedge clk);
    checkEq("overflow[4]", 0, overflow[portS]); // Buffer is full but nothing was lost yet
    repeat (3) @(negedge clk);
    checkEq("overflow[4]", 1, overflow[portS]);
    repeat (10) @(negedge clk);
    checkEq("overflow[4]", 1, overflow[portS]);
    $display("test southOverflow finished, errors %0d", errors);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    #(timeLimit);
    $display("Timeout: the run did not finish within %0d time units", timeLimit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
hdl/nocFlitPkg.sv
hdl/nocRouterPkg.sv
hdl/flitFifo.sv
hdl/packetTimer.sv
hdl/switchArbiter.sv
hdl/outputStage.sv
hdl/routerOutputPort.sv
dv/routerOutputPort_assertions.sv
dv/routerOutputPortTb.sv

/* runSim.sh */
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module routerOutputPortTb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VrouterOutputPortTb > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

grep -qF "*** TEST PASSED ***" sim.log
if [ $? -ne 0 ]; then
  echo "Pass message not found in sim.log"
  exit 1
fi

echo "Simulation passed"
exit 0
